/* hw/status_i2c_pkg.sv */
// status controller i2c slave
// shared widths, states and bus structs

package status_i2c_pkg;

	// ************************************************************************
	// widths
	// ************************************************************************
	localparam int addr_w    = 7;   // device address
	localparam int byte_w    = 8;   // one data byte on the bus
	localparam int num_ports = 16;  // ports behind the location high nibble
	localparam int nib_w     = 4;   // port / offset index
	localparam int bit_cnt_w = 4;   // counts 0..9, 9 is the ack bit

	// one-hot transaction states
	typedef enum logic [4:0]
	{
		st_idle = 5'b00001,  // bus free or not addressed
		st_addr = 5'b00010,  // device address byte
		st_loc  = 5'b00100,  // location byte of a write
		st_data = 5'b01000,  // data byte, either direction
		st_end  = 5'b10000   // access done, wait for stop or restart
	} i2c_state_e;

	// ************************************************************************
	// shared structs
	// ************************************************************************

	// bus events, all registered in the sampler
	typedef struct packed
	{
		logic scl_lvl;   // synchronised scl
		logic sda_lvl;   // synchronised sda
		logic scl_rise;
		logic scl_fall;
		logic sda_rise;
		logic sda_fall;
		logic start;     // sda fall with scl high
		logic stop;      // sda rise with scl high
	} bus_ev_t;

	// transaction status from the fsm to the sda driver
	typedef struct packed
	{
		i2c_state_e             state;
		logic [bit_cnt_w-1:0]   bit_cnt;
		logic                   rd_wr;     // 1 = read
		logic                   addr_ok;   // address byte matched
		logic                   loc_tick;  // read location advanced
	} xfer_t;

	// read data of all ports, one byte each
	typedef logic [byte_w-1:0] port_bus_t [num_ports];

endpackage

/* hw/i2c_bus_sampler.sv */
// i2c line sampler
// scl/sda synchronisers, edges and bus conditions

module i2c_bus_sampler
(
	input  logic                    SYSCLK,
	input  logic                    RESET_N,
	input  logic                    scl,
	input  logic                    sda_in,
	output status_i2c_pkg::bus_ev_t ev
);

	logic scl_d1;  // first sync stage
	logic scl_d2;  // second sync stage
	logic sda_d1;
	logic sda_d2;

	logic scl_rise_w;
	logic scl_fall_w;
	logic sda_rise_w;
	logic sda_fall_w;

	// edges between the two sync stages
	assign scl_rise_w = scl_d1 & ~scl_d2;
	assign scl_fall_w = ~scl_d1 & scl_d2;
	assign sda_rise_w = sda_d1 & ~sda_d2;
	assign sda_fall_w = ~sda_d1 & sda_d2;

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			scl_d1 <= 1'b1;  // idle bus is high, no false edge after reset
			scl_d2 <= 1'b1;
			sda_d1 <= 1'b1;
			sda_d2 <= 1'b1;
			ev     <= '{scl_lvl: 1'b1, sda_lvl: 1'b1, default: 1'b0};
		end
		else
		begin
			scl_d1 <= scl;
			scl_d2 <= scl_d1;
			sda_d1 <= sda_in;
			sda_d2 <= sda_d1;
			// event outputs, one cycle pulses
			ev.scl_lvl  <= scl_d1;
			ev.sda_lvl  <= sda_d1;
			ev.scl_rise <= scl_rise_w;
			ev.scl_fall <= scl_fall_w;
			ev.sda_rise <= sda_rise_w;
			ev.sda_fall <= sda_fall_w;
			ev.start    <= sda_fall_w & scl_d1 & scl_d2;  // scl stable high
			ev.stop     <= sda_rise_w & scl_d1 & scl_d2;
		end
	end

endmodule

/* hw/i2c_slave_fsm.sv */
// i2c slave transaction fsm
// bit count, input shifter, address match, location and write data

module i2c_slave_fsm
(
	input  logic                                    SYSCLK,
	input  logic                                    RESET_N,
	input  status_i2c_pkg::bus_ev_t                 ev,
	input  logic [status_i2c_pkg::addr_w-1:0]       dev_address,
	input  logic                                    master_nack,
	output status_i2c_pkg::xfer_t                   xfer,
	output logic [status_i2c_pkg::byte_w-1:0]       loc,
	output logic [status_i2c_pkg::byte_w-1:0]       dout,
	output logic                                    rd_en,
	output logic                                    wr_en
);
	import status_i2c_pkg::*;

	i2c_state_e           state;
	logic [bit_cnt_w-1:0] bit_cnt;
	logic [byte_w-1:0]    shift_in;   // sda bits, msb first
	logic                 rd_wr;
	logic                 addr_ok;
	logic                 loc_tick;
	logic                 rise_d1;    // scl rise delayed one cycle

	logic cnt8;
	logic cnt9;
	logic next_byte;    // scl fall at the end of the ack bit
	logic byte_done;    // scl fall right after the 8th data bit

	assign cnt8      = (bit_cnt == bit_cnt_w'(8));
	assign cnt9      = (bit_cnt == bit_cnt_w'(9));
	assign next_byte = cnt9 & ev.scl_fall;
	assign byte_done = cnt8 & ev.scl_fall;

	// ************************************************************************
	// bit counter and input shifter
	// ************************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			bit_cnt <= '0;
		else if (ev.start | ev.stop | next_byte)
			bit_cnt <= '0;
		else if (ev.scl_rise && state != st_idle)
			bit_cnt <= bit_cnt + 1'b1;  // counts sampled bits
	end

	always_ff @(posedge SYSCLK)
	begin
		if (ev.scl_rise)
			shift_in <= {shift_in[byte_w-2:0], ev.sda_lvl};
	end

	// address byte: r/w bit and match, once 8 bits are in
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			rd_wr   <= 1'b0;
			addr_ok <= 1'b0;
		end
		else if (ev.start | ev.stop)
		begin
			rd_wr   <= 1'b0;
			addr_ok <= 1'b0;
		end
		else if (state == st_addr && cnt8)
		begin
			rd_wr   <= shift_in[0];
			addr_ok <= (shift_in[byte_w-1:1] == dev_address);
		end
	end

	// ************************************************************************
	// state
	// ************************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			state <= st_idle;
		else if (ev.start)
			state <= st_addr;  // start and repeated start
		else if (ev.stop)
			state <= st_idle;
		else if (next_byte)
		begin
			case (state)
				st_addr: state <= !addr_ok ? st_idle : (rd_wr ? st_data : st_loc);
				st_loc:  state <= st_data;
				st_data: state <= (rd_wr & master_nack) ? st_idle : st_end;
				default: state <= st_idle;  // st_end, extra bytes are not taken
			endcase
		end
	end

	// location and write data, latched on the scl fall after bit 8
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			loc      <= '0;
			dout     <= '0;
			loc_tick <= 1'b0;
		end
		else
		begin
			loc_tick <= byte_done & (state == st_data) & rd_wr;
			if (byte_done && state == st_loc)
				loc <= shift_in;
			else if (byte_done && state == st_data && rd_wr)
				loc <= loc + 1'b1;  // next read fetches the following location
			if (byte_done && state == st_data && !rd_wr)
				dout <= shift_in;
		end
	end

	// access strobes
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			rise_d1 <= 1'b0;
			rd_en   <= 1'b0;
			wr_en   <= 1'b0;
		end
		else
		begin
			rise_d1 <= ev.scl_rise;
			// ack bit of a matched read address
			rd_en   <= rise_d1 & cnt9 & (state == st_addr) & addr_ok & rd_wr;
			// first scl rise after the data ack, bit_cnt moves on so only once
			wr_en   <= ev.scl_rise & (bit_cnt == '0) & (state == st_end) & ~rd_wr;
		end
	end

	assign xfer = '{state: state, bit_cnt: bit_cnt, rd_wr: rd_wr,
		addr_ok: addr_ok, loc_tick: loc_tick};

endmodule

/* hw/i2c_sda_driver.sv */
// i2c sda driver
// ack generation, read data shifter, master nack

module i2c_sda_driver
(
	input  logic                                SYSCLK,
	input  logic                                RESET_N,
	input  status_i2c_pkg::bus_ev_t             ev,
	input  status_i2c_pkg::xfer_t               xfer,
	input  logic [status_i2c_pkg::byte_w-1:0]   rd_byte,
	output logic                                sda_oe,
	output logic                                sda_out,
	output logic                                master_nack
);
	import status_i2c_pkg::*;

	logic [byte_w-1:0] shift_out;  // remaining read bits, msb next
	logic              quiet;      // sda must be released
	logic              rd_data;    // read data phase
	logic              ack_me;     // slave acks the current byte
	logic              load;       // end of matched read address ack

	assign quiet   = (xfer.state == st_idle) | (xfer.state == st_end) | ev.start | ev.stop;
	assign rd_data = (xfer.state == st_data) & xfer.rd_wr;
	assign ack_me  = (xfer.state == st_addr) ? xfer.addr_ok : ~rd_data;
	assign load    = (xfer.state == st_addr) & xfer.addr_ok & xfer.rd_wr;

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			sda_oe    <= 1'b0;
			sda_out   <= 1'b1;
			shift_out <= '1;
		end
		else if (quiet)
		begin
			sda_oe  <= 1'b0;
			sda_out <= 1'b1;
		end
		else if (ev.scl_fall)  // sda changes only while scl is low
		begin
			if (xfer.bit_cnt == bit_cnt_w'(8))
			begin
				sda_oe  <= ack_me;  // ack, or let the master ack a read byte
				sda_out <= 1'b0;
			end
			else if (xfer.bit_cnt == bit_cnt_w'(9))
			begin
				sda_oe    <= load;
				sda_out   <= load ? rd_byte[byte_w-1] : 1'b1;  // bit 7 of read data
				shift_out <= {rd_byte[byte_w-2:0], 1'b1};
			end
			else
			begin
				sda_oe    <= rd_data & ~master_nack;
				sda_out   <= shift_out[byte_w-1];
				shift_out <= {shift_out[byte_w-2:0], 1'b1};
			end
		end
		else if (xfer.loc_tick)
			shift_out <= '1;  // byte sent, nothing left to shift
	end

	// ************************************************************************
	// master ack/nack after a read byte, sampled on the 9th scl rise
	// ************************************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			master_nack <= 1'b0;
		else if (ev.start)
			master_nack <= 1'b0;
		else if (ev.scl_rise && rd_data && xfer.bit_cnt == bit_cnt_w'(8))
			master_nack <= ev.sda_lvl;  // high = nack, end of read
	end

endmodule

/* hw/port_select.sv */
// port and offset select
// one-hot decode of the location, read data capture

module port_select
(
	input  logic                                    SYSCLK,
	input  logic                                    RESET_N,
	input  logic [status_i2c_pkg::byte_w-1:0]       loc,
	input  logic                                    rd_en,
	input  logic                                    wr_en,
	input  status_i2c_pkg::port_bus_t               din,
	output logic [status_i2c_pkg::num_ports-1:0]    port_cs,
	output logic [status_i2c_pkg::num_ports-1:0]    offset_sel,
	output logic [status_i2c_pkg::byte_w-1:0]       rd_byte
);
	import status_i2c_pkg::*;

	logic [nib_w-1:0]     port_idx;   // loc high nibble
	logic [nib_w-1:0]     offset_idx; // loc low nibble
	logic [num_ports-1:0] port_dec;
	logic                 rd_cap;     // rd_en delayed, aligned with port_cs

	assign port_idx   = loc[byte_w-1:nib_w];
	assign offset_idx = loc[nib_w-1:0];

	assign port_dec   = num_ports'(1) << port_idx;
	assign offset_sel = num_ports'(1) << offset_idx;  // always valid

	// port_cs pulse, one cycle per access
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			port_cs <= '0;
			rd_cap  <= 1'b0;
		end
		else
		begin
			port_cs <= (rd_en | wr_en) ? port_dec : '0;
			rd_cap  <= rd_en;
		end
	end

	// read byte from the selected port while its cs is up
	always_ff @(posedge SYSCLK)
	begin
		if (rd_cap)
			rd_byte <= din[port_idx];
	end

endmodule

/* hw/status_i2c_top.sv */
// status controller i2c slave top

module status_i2c_top
(
	input  logic                                    SYSCLK,
	input  logic                                    RESET_N,
	input  logic                                    scl,
	input  logic                                    sda_in,
	input  logic [status_i2c_pkg::addr_w-1:0]       dev_address,
	input  status_i2c_pkg::port_bus_t               din,
	output logic                                    sda_oe,
	output logic                                    sda_out,
	output logic [status_i2c_pkg::byte_w-1:0]       dout,
	output logic                                    rd_wr,
	output logic [status_i2c_pkg::num_ports-1:0]    port_cs,
	output logic [status_i2c_pkg::num_ports-1:0]    offset_sel
);
	import status_i2c_pkg::*;

	bus_ev_t           ev;
	xfer_t             xfer;
	logic [byte_w-1:0] loc;
	logic [byte_w-1:0] rd_byte;
	logic              rd_en;
	logic              wr_en;
	logic              master_nack;

	assign rd_wr = xfer.rd_wr;

	i2c_bus_sampler sampler_i
	(
		.SYSCLK  (SYSCLK),
		.RESET_N (RESET_N),
		.scl     (scl),
		.sda_in  (sda_in),
		.ev      (ev)
	);

	i2c_slave_fsm fsm_i
	(
		.SYSCLK      (SYSCLK),
		.RESET_N     (RESET_N),
		.ev          (ev),
		.dev_address (dev_address),
		.master_nack (master_nack),
		.xfer        (xfer),
		.loc         (loc),
		.dout        (dout),
		.rd_en       (rd_en),
		.wr_en       (wr_en)
	);

	i2c_sda_driver sda_i
	(
		.SYSCLK      (SYSCLK),
		.RESET_N     (RESET_N),
		.ev          (ev),
		.xfer        (xfer),
		.rd_byte     (rd_byte),
		.sda_oe      (sda_oe),
		.sda_out     (sda_out),
		.master_nack (master_nack)
	);

	port_select port_i
	(
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.loc        (loc),
		.rd_en      (rd_en),
		.wr_en      (wr_en),
		.din        (din),
		.port_cs    (port_cs),
		.offset_sel (offset_sel),
		.rd_byte    (rd_byte)
	);

endmodule

/* dv/status_i2c_props.sv */
// status i2c top assertions

module status_i2c_props
(
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  logic [15:0]           port_cs,
	input  logic [15:0]           offset_sel,
	input  logic                  sda_oe,
	input  status_i2c_pkg::xfer_t xfer
);
	import status_i2c_pkg::*;

	int fail_cnt = 0;  // failed assertions, part of the final error count

	a_cs_onehot: assert property (@(posedge SYSCLK) disable iff (!RESET_N) $onehot0(port_cs))
		else
		begin
			fail_cnt++;
			$error("port_cs has more than one bit set");
		end
	a_off_onehot: assert property (@(posedge SYSCLK) disable iff (!RESET_N) $onehot(offset_sel))
		else
		begin
			fail_cnt++;
			$error("offset_sel is not one-hot");
		end
	// strobe lasts one cycle
	a_cs_pulse: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		(port_cs != '0) |=> (port_cs == '0))
		else
		begin
			fail_cnt++;
			$error("port_cs held longer than one cycle");
		end
	a_idle_quiet: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		(xfer.state == st_idle) |-> !sda_oe)
		else
		begin
			fail_cnt++;
			$error("sda driven while idle");
		end

endmodule

bind status_i2c_top status_i2c_props props_i
(
	.SYSCLK(SYSCLK), .RESET_N(RESET_N), .port_cs(port_cs),
	.offset_sel(offset_sel), .sda_oe(sda_oe), .xfer(xfer)
);

/* dv/status_i2c_checker.sv */
// port access checker

module status_i2c_checker
(
	input  logic        SYSCLK,
	input  logic        RESET_N,
	input  logic [15:0] port_cs,
	input  logic [15:0] offset_sel,
	input  logic [7:0]  dout,
	input  logic        rd_wr,
	input  logic        exp_push,    // one cycle, adds an expected access
	input  logic [3:0]  exp_port,
	input  logic [3:0]  exp_offset,
	input  logic [7:0]  exp_data,
	input  logic        exp_write,
	output int          err_cnt,
	output int          pending      // accesses still waiting for a pulse
);

	logic [16:0] exp_q[$];  // {write, port, offset, data}
	logic [16:0] e;

	initial err_cnt = 0;

	always @(posedge SYSCLK)
	begin
		if (exp_push)
			exp_q.push_back({exp_write, exp_port, exp_offset, exp_data});
		if (RESET_N && port_cs != '0)
		begin
			if (exp_q.size() == 0)
			begin
				err_cnt++;
				$display("ERR %0t: port_cs %h with no access expected", $time, port_cs);
			end
			else
			begin
				e = exp_q.pop_front();
				if (port_cs != (16'd1 << e[15:12]) || offset_sel != (16'd1 << e[11:8]))
				begin
					err_cnt++;
					$display("ERR %0t: port_cs %h offset_sel %h, expected port %0d offset %0d",
						$time, port_cs, offset_sel, e[15:12], e[11:8]);
				end
				if (rd_wr != ~e[16])  // read access pulses with rd_wr high
				begin
					err_cnt++;
					$display("ERR %0t: rd_wr %b on %s access", $time, rd_wr,
						e[16] ? "write" : "read");
				end
				if (e[16] && dout != e[7:0])
				begin
					err_cnt++;
					$display("ERR %0t: dout %h, expected %h", $time, dout, e[7:0]);
				end
			end
		end
		pending = exp_q.size();
	end

endmodule

/* dv/tb_status_i2c.sv */
// status i2c slave testbench
// bit-banged i2c master, open drain bus model and reference

module tb_status_i2c;
	import status_i2c_pkg::*;

	localparam logic [addr_w-1:0] dev_addr = 7'h3a;
	localparam int tx_limit = 40 * 400;  // 40 transactions at 400 cycles, about twice the run

	logic SYSCLK = 1'b0;
	logic RESET_N;
	logic scl;
	logic sda_m;      // master side of sda
	logic sda_line;   // wired-and bus
	port_bus_t din;
	logic sda_oe;
	logic sda_out;
	logic [byte_w-1:0] dout;
	logic rd_wr;
	logic [num_ports-1:0] port_cs;
	logic [num_ports-1:0] offset_sel;
	logic exp_push;
	logic [nib_w-1:0] exp_port;
	logic [nib_w-1:0] exp_offset;
	logic [byte_w-1:0] exp_data;
	logic exp_write;
	int chk_errs;
	int chk_pending;
	int errs = 0;
	int cycles = 0;
	logic [byte_w-1:0] loc_model;  // location as the slave should hold it

	assign sda_line = sda_m & (sda_oe ? sda_out : 1'b1);  // open drain

	always #5 SYSCLK = ~SYSCLK;

	status_i2c_top dut_i
	(
		.SYSCLK(SYSCLK), .RESET_N(RESET_N), .scl(scl), .sda_in(sda_line),
		.dev_address(dev_addr), .din(din), .sda_oe(sda_oe), .sda_out(sda_out),
		.dout(dout), .rd_wr(rd_wr), .port_cs(port_cs), .offset_sel(offset_sel)
	);

	status_i2c_checker chk_i
	(
		.SYSCLK(SYSCLK), .RESET_N(RESET_N), .port_cs(port_cs), .offset_sel(offset_sel),
		.dout(dout), .rd_wr(rd_wr), .exp_push(exp_push), .exp_port(exp_port),
		.exp_offset(exp_offset), .exp_data(exp_data), .exp_write(exp_write),
		.err_cnt(chk_errs), .pending(chk_pending)
	);

	// reference: a read returns the din byte of the port in the high nibble
	function automatic logic [byte_w-1:0] exp_read(input logic [byte_w-1:0] l);
		return din[l[byte_w-1:nib_w]];
	endfunction

	always @(posedge SYSCLK)
	begin
		cycles++;
		if (cycles == tx_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", tx_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic wait_clks(input int n);
		repeat (n) @(posedge SYSCLK);
	endtask

	// ************************************************************************
	// i2c master, 8 cycles per scl phase
	// ************************************************************************
	task automatic bus_start();  // also serves as repeated start
		sda_m <= 1'b1;
		wait_clks(8);
		scl <= 1'b1;
		wait_clks(8);
		sda_m <= 1'b0;  // sda falls with scl high
		wait_clks(8);
		scl <= 1'b0;
		wait_clks(2);
	endtask

	task automatic bus_stop();
		sda_m <= 1'b0;
		wait_clks(6);
		scl <= 1'b1;
		wait_clks(8);
		sda_m <= 1'b1;  // sda rises with scl high
		wait_clks(8);
	endtask

	task automatic send_bit(input logic b);
		sda_m <= b;
		wait_clks(6);
		scl <= 1'b1;
		wait_clks(8);
		scl <= 1'b0;
		wait_clks(2);  // hold sda past the fall
	endtask

	task automatic recv_bit(output logic v);
		sda_m <= 1'b1;  // release, slave drives
		wait_clks(6);
		scl <= 1'b1;
		wait_clks(4);
		v = sda_line;   // mid high phase, line is stable
		wait_clks(4);
		scl <= 1'b0;
		wait_clks(2);
	endtask

	task automatic send_checked(input logic [byte_w-1:0] b, input logic want_ack);
		logic a;
		for (int i = byte_w - 1; i >= 0; i--)
			send_bit(b[i]);
		recv_bit(a);
		if (a != ~want_ack)
		begin
			errs++;
			$display("ERR %0t: byte %h ack bit %b, expected %b", $time, b, a, ~want_ack);
		end
	endtask

	task automatic expect_access(input logic [byte_w-1:0] l, input logic [byte_w-1:0] d,
		input logic w);
		exp_port   <= l[byte_w-1:nib_w];
		exp_offset <= l[nib_w-1:0];
		exp_data   <= d;
		exp_write  <= w;
		exp_push   <= 1'b1;
		@(posedge SYSCLK);
		exp_push   <= 1'b0;
	endtask

	// ************************************************************************
	// transactions
	// ************************************************************************
	task automatic write_access(input logic [byte_w-1:0] l, input logic [byte_w-1:0] d);
		expect_access(l, d, 1'b1);
		bus_start();
		send_checked({dev_addr, 1'b0}, 1'b1);
		send_checked(l, 1'b1);
		send_checked(d, 1'b1);
		bus_stop();  // scl rise of the stop fires the write strobe
		loc_model = l;
	endtask

	task automatic set_location(input logic [byte_w-1:0] l);
		bus_start();
		send_checked({dev_addr, 1'b0}, 1'b1);
		send_checked(l, 1'b1);
		bus_stop();
		loc_model = l;
	endtask

	task automatic read_access();
		logic [byte_w-1:0] rd;
		logic b;
		expect_access(loc_model, 8'h00, 1'b0);
		bus_start();
		send_checked({dev_addr, 1'b1}, 1'b1);
		for (int i = byte_w - 1; i >= 0; i--)
		begin
			recv_bit(b);
			rd[i] = b;
		end
		send_bit(1'b1);  // master nack ends the read
		bus_stop();
		if (rd != exp_read(loc_model))
		begin
			errs++;
			$display("ERR %0t: read loc %h got %h, expected %h", $time, loc_model, rd,
				exp_read(loc_model));
		end
		loc_model = loc_model + 8'd1;  // slave moves to the next location
	endtask

	task automatic wrong_address();
		bus_start();
		send_checked({dev_addr ^ 7'h01, 1'b0}, 1'b0);  // sda must stay high
		bus_stop();
	endtask

	task automatic aborted_write();
		bus_start();
		send_checked({dev_addr, 1'b0}, 1'b1);
		send_checked(8'($urandom), 1'b1);
		write_access(8'($urandom), 8'($urandom));  // starts with a repeated start
	endtask

	initial
	begin
		void'($urandom(32'h7706));
		RESET_N    <= 1'b0;
		scl        <= 1'b1;
		sda_m      <= 1'b1;
		exp_push   <= 1'b0;
		exp_port   <= '0;
		exp_offset <= '0;
		exp_data   <= '0;
		exp_write  <= 1'b0;
		loc_model  = '0;
		for (int i = 0; i < num_ports; i++)
			din[i] <= 8'($urandom);
		repeat (3) @(posedge SYSCLK);
		RESET_N <= 1'b1;
		wait_clks(4);
		if (port_cs != '0 || sda_oe)
		begin
			errs++;
			$display("ERR %0t: port_cs %h sda_oe %b after reset", $time, port_cs, sda_oe);
		end
		read_access();  // location 0 after reset
		for (int i = 0; i < 6; i++)
			write_access(8'($urandom), 8'($urandom));
		wrong_address();
		wrong_address();
		set_location({4'($urandom), 4'hd});  // reads cross into the next port
		for (int i = 0; i < 5; i++)
			read_access();
		set_location(8'hfe);  // location wraps to 0
		for (int i = 0; i < 3; i++)
			read_access();
		aborted_write();
		aborted_write();
		wait_clks(20);
		if (chk_pending != 0)
		begin
			errs++;
			$display("%0d expected port accesses never happened", chk_pending);
		end
		$display("errors: testbench %0d, checker %0d, assertions %0d", errs, chk_errs,
			dut_i.props_i.fail_cnt);
		if (errs + chk_errs + dut_i.props_i.fail_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* compile.f */
hw/status_i2c_pkg.sv
hw/i2c_bus_sampler.sv
hw/i2c_slave_fsm.sv
hw/i2c_sda_driver.sv
hw/port_select.sv
hw/status_i2c_top.sv
dv/status_i2c_props.sv
dv/status_i2c_checker.sv
dv/tb_status_i2c.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_status_i2c
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
